//--- hdl/fetch_pkg.sv
package fetch_pkg;

    // --------------------
    // Datapath widths
    localparam int xlen          = 32;
    localparam int inst_bits     = 32;
    localparam int inst_bytes    = inst_bits / 8;     // PC step per instruction

    // --------------------
    // Memory bus
    localparam int mem_tag_width = 4;                 // Tag zero means no transaction

    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2                              // Not used by the fetch path
    } bus_command_t;

    // --------------------
    // Cache line and memory word geometry
    localparam int line_bytes    = 8;
    localparam int line_bits     = line_bytes * 8;
    localparam int offset_bits   = $clog2(line_bytes); // Address bits 2:0

endpackage

//--- hdl/icache.sv
module icache import fetch_pkg::*; #(
    parameter int cache_lines = 32
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic [xlen-1:0]          fetch_addr,
    input  logic [mem_tag_width-1:0] mem_response,
    input  logic [line_bits-1:0]     mem_data,
    input  logic [mem_tag_width-1:0] mem_tag,
    output bus_command_t             mem_command,
    output logic [xlen-1:0]          mem_addr,
    output logic [line_bits-1:0]     line_data,
    output logic                     line_valid
);

    localparam int index_bits = $clog2(cache_lines);
    localparam int tag_bits   = xlen - offset_bits - index_bits;

    // --------------------
    // Address split
    logic [xlen-offset_bits-1:0] line_addr;
    logic [xlen-offset_bits-1:0] last_line;
    logic [index_bits-1:0]       cur_index;
    logic [tag_bits-1:0]         cur_tag;

    assign line_addr            = fetch_addr[xlen-1:offset_bits];
    assign {cur_tag, cur_index} = line_addr;

    // --------------------
    // Storage
    logic [line_bits-1:0]   data_array [cache_lines];
    logic [tag_bits-1:0]    tag_array  [cache_lines];
    logic [cache_lines-1:0] valid_array;

    // Miss tracking
    logic                     miss_outstanding;
    logic [mem_tag_width-1:0] pend_tag;       // Tag of the accepted load
    logic [index_bits-1:0]    pend_index;     // Line the load was issued for
    logic [tag_bits-1:0]      pend_line_tag;

    logic changed_addr;
    logic in_flight;
    logic issue;
    logic accepted;
    logic write_en;
    logic fill;
    logic evict;

    assign line_data  = data_array[cur_index];
    assign line_valid = valid_array[cur_index] && (tag_array[cur_index] == cur_tag);

    assign changed_addr = (line_addr != last_line);
    assign in_flight    = (pend_tag != '0);
    assign write_en     = in_flight && (mem_tag == pend_tag);

    // Returning line lands on the current index
    assign fill  = write_en && (pend_index == cur_index) && (pend_line_tag == cur_tag);
    assign evict = write_en && (pend_index == cur_index) && (pend_line_tag != cur_tag);

    // One load in flight at a time, and never while the address moves
    assign issue    = miss_outstanding && !changed_addr && !in_flight;
    assign accepted = issue && (mem_response != '0);

    assign mem_command = issue ? bus_load : bus_none;
    assign mem_addr    = {line_addr, {offset_bits{1'b0}}};

    // --------------------
    // Control state
    always_ff @(posedge clock) begin
        if (reset) begin
            last_line        <= ~line_addr;   // First cycle out of reset sees a change
            miss_outstanding <= 1'b0;
            pend_tag         <= '0;
            valid_array      <= '0;
        end else begin
            last_line <= line_addr;

            if (accepted || fill) begin
                miss_outstanding <= 1'b0;
            end else if (evict) begin
                miss_outstanding <= 1'b1;     // Current line overwritten by older load
            end else if (changed_addr) begin
                miss_outstanding <= !line_valid;
            end

            if (accepted) begin
                pend_tag <= mem_response;
            end else if (write_en) begin
                pend_tag <= '0;
            end

            if (write_en) begin
                valid_array[pend_index] <= 1'b1;
            end
        end
    end

    // --------------------
    // Line data and tags
    always_ff @(posedge clock) begin
        if (accepted) begin
            pend_index    <= cur_index;
            pend_line_tag <= cur_tag;
        end
        if (write_en) begin
            data_array[pend_index] <= mem_data;
            tag_array[pend_index]  <= pend_line_tag;
        end
    end

endmodule

//--- hdl/fetch_stage.sv
module fetch_stage import fetch_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = '0
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic [line_bits-1:0] line_data,
    input  logic                 line_valid,
    input  logic                 inst_ready,
    input  logic                 redirect_valid,
    input  logic [xlen-1:0]      redirect_pc,
    output logic [xlen-1:0]      fetch_addr,
    output logic [inst_bits-1:0] inst,
    output logic [xlen-1:0]      inst_pc,
    output logic                 inst_valid
);

    logic [xlen-1:0]      pc;
    logic [inst_bits-1:0] line_word;
    logic [inst_bits-1:0] held_inst;
    logic                 held_valid;
    logic                 transfer;
    logic                 stall;

    assign fetch_addr = pc;
    assign inst_pc    = pc;

    // --------------------
    // Instruction select
    assign line_word = pc[offset_bits-1] ? line_data[line_bits-1 -: inst_bits]
                                         : line_data[inst_bits-1:0];

    // A stalled instruction stays offered even if a late fill evicts its line
    assign inst       = held_valid ? held_inst : line_word;
    assign inst_valid = (line_valid || held_valid) && !redirect_valid;

    assign transfer = inst_valid && inst_ready;
    assign stall    = inst_valid && !inst_ready;

    // --------------------
    // Program counter
    always_ff @(posedge clock) begin
        if (reset) begin
            pc         <= reset_pc;
            held_valid <= 1'b0;
        end else begin
            if (redirect_valid) begin
                pc <= redirect_pc;                // Redirect wins over a transfer
            end else if (transfer) begin
                pc <= pc + xlen'(inst_bytes);
            end
            held_valid <= stall;
        end
    end

    always_ff @(posedge clock) begin
        if (stall) begin
            held_inst <= inst;
        end
    end

endmodule

//--- hdl/fetch_top.sv
module fetch_top import fetch_pkg::*; #(
    parameter int              cache_lines = 32,
    parameter logic [xlen-1:0] reset_pc    = '0
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic [mem_tag_width-1:0] mem_response,
    input  logic [line_bits-1:0]     mem_data,
    input  logic [mem_tag_width-1:0] mem_tag,
    input  logic                     inst_ready,
    input  logic                     redirect_valid,
    input  logic [xlen-1:0]          redirect_pc,
    output bus_command_t             mem_command,
    output logic [xlen-1:0]          mem_addr,
    output logic [inst_bits-1:0]     inst,
    output logic [xlen-1:0]          inst_pc,
    output logic                     inst_valid
);

    // --------------------
    // Fetch to cache
    logic [xlen-1:0]      fetch_addr;
    logic [line_bits-1:0] line_data;
    logic                 line_valid;

    fetch_stage #(
        .reset_pc       (reset_pc)
    ) i_fetch_stage (
        .clock          (clock),
        .reset          (reset),
        .line_data      (line_data),
        .line_valid     (line_valid),
        .inst_ready     (inst_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_addr     (fetch_addr),
        .inst           (inst),
        .inst_pc        (inst_pc),
        .inst_valid     (inst_valid)
    );

    icache #(
        .cache_lines    (cache_lines)
    ) i_icache (
        .clock          (clock),
        .reset          (reset),
        .fetch_addr     (fetch_addr),
        .mem_response   (mem_response),
        .mem_data       (mem_data),
        .mem_tag        (mem_tag),
        .mem_command    (mem_command),
        .mem_addr       (mem_addr),
        .line_data      (line_data),
        .line_valid     (line_valid)
    );

endmodule

//--- testbench/imem_model.sv
module imem_model import fetch_pkg::*; #(
    parameter int latency = 6
) (
    input  logic                     clock,
    input  logic                     reset,
    input  bus_command_t             mem_command,
    input  logic [xlen-1:0]          mem_addr,
    output logic [mem_tag_width-1:0] mem_response,
    output logic [line_bits-1:0]     mem_data,
    output logic [mem_tag_width-1:0] mem_tag
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int refuse_period = 7;             // Every seventh request is refused

    logic [mem_tag_width-1:0] next_tag;
    int                       request_count;
    logic                     load_request;
    logic [mem_tag_width-1:0] tag_pipe  [latency];
    logic [line_bits-1:0]     data_pipe [latency];

    // Upper half is line*3+1, lower half is the inverted line number
    function automatic logic [line_bits-1:0] word_at(input logic [xlen-1:0] addr);
        logic [xlen-1:0] line;
        line = addr >> offset_bits;
        return {xlen'(line * 3 + 1), ~line};
    endfunction

    assign load_request = (mem_command == bus_load);
    assign mem_response = (load_request && request_count != refuse_period - 1) ? next_tag : '0;
    assign mem_tag      = tag_pipe[latency-1];
    assign mem_data     = data_pipe[latency-1];

    // --------------------
    // Fixed latency return pipe
    always_ff @(posedge clock) begin
        if (reset) begin
            next_tag      <= 1;
            request_count <= 0;
            for (int i = 0; i < latency; i++) begin
                tag_pipe[i] <= '0;
            end
        end else begin
            if (load_request) begin
                request_count <= (request_count == refuse_period - 1) ? 0 : request_count + 1;
            end
            if (mem_response != '0) begin
                next_tag <= (next_tag == '1) ? 1 : next_tag + 1;   // Tags cycle 1 to 15
            end
            tag_pipe[0]  <= mem_response;
            data_pipe[0] <= word_at(mem_addr);
            for (int i = 1; i < latency; i++) begin
                tag_pipe[i]  <= tag_pipe[i-1];
                data_pipe[i] <= data_pipe[i-1];
            end
        end
    end

endmodule

//--- testbench/tb_fetch.sv
module tb_fetch import fetch_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int              cache_lines      = 32;
    localparam int              mem_latency      = 6;
    localparam logic [xlen-1:0] reset_pc         = 32'h0000_1000;
    localparam logic [xlen-1:0] window_base      = reset_pc;   // 1 KB redirect window
    localparam logic [xlen-1:0] loop_base        = window_base + 32'h200;
    localparam int              stream_transfers = 200;
    localparam int              loop_length      = 8;          // Four lines
    // Every transfer a twice-refused miss, plus back-pressure slack
    localparam int              timeout_cycles   = stream_transfers * (2 * (mem_latency + 2) + 4);

    logic                     clock;
    logic                     reset;
    logic [mem_tag_width-1:0] mem_response;
    logic [line_bits-1:0]     mem_data;
    logic [mem_tag_width-1:0] mem_tag;
    logic                     inst_ready;
    logic                     redirect_valid;
    logic [xlen-1:0]          redirect_pc;
    bus_command_t             mem_command;
    logic [xlen-1:0]          mem_addr;
    logic [inst_bits-1:0]     inst;
    logic [xlen-1:0]          inst_pc;
    logic                     inst_valid;

    // Reference model and shadow cache
    logic [xlen-1:0]          model_pc;
    logic                     stalled;
    logic [inst_bits-1:0]     stall_inst;
    logic [xlen-1:0]          stall_pc;
    logic [mem_tag_width-1:0] pending_tag;
    logic [xlen-1:0]          pending_line;
    logic [xlen-1:0]          shadow_line  [cache_lines];
    logic                     shadow_valid [cache_lines];
    logic [xlen-1:0]          last_load_addr;
    int                       load_count   = 0;
    int                       transfers    = 0;
    int                       cycle_count  = 0;
    int                       error_count  = 0;
    int                       test_errors  = 0;
    int                       tests_run    = 0;
    int                       tests_failed = 0;
    string                    current_test;

    fetch_top #(.cache_lines(cache_lines), .reset_pc(reset_pc)) i_fetch_top (.*);

    imem_model #(.latency(mem_latency)) i_imem_model (
        .clock(clock), .reset(reset), .mem_command(mem_command), .mem_addr(mem_addr),
        .mem_response(mem_response), .mem_data(mem_data), .mem_tag(mem_tag)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_count >= timeout_cycles);
        $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("Simulation failed");
        $finish;
    end

    // --------------------
    // Model helpers
    function automatic logic [inst_bits-1:0] expected_inst(input logic [xlen-1:0] addr);
        logic [xlen-1:0] line;
        line = addr >> offset_bits;
        return addr[2] ? line * 3 + 1 : ~line;
    endfunction

    function automatic logic random_ready();
        return ($urandom % 4) != 0;                 // 75% ready
    endfunction

    task automatic report_mismatch(input string what, input logic [xlen-1:0] expected,
                                   input logic [xlen-1:0] actual);
        error_count++;
        $display("** Error [%s] %s: expected %h, actual %h at %0t",
                 current_test, what, expected, actual, $time);
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("Error [%s] %s at %0t", current_test, what, $time);
    endtask

    task automatic start_test(input string name);
        current_test = name;
        test_errors  = error_count;
    endtask

    task automatic finish_test();
        tests_run++;
        if (error_count == test_errors) begin
            $display("Test %-9s ok, %0d transfers so far", current_test, transfers);
        end else begin
            tests_failed++;
            $display("Test %-9s FAILED with %0d errors", current_test, error_count - test_errors);
        end
    endtask

    // Sampled at the falling edge, after the inputs have settled
    task automatic observe();
        if (mem_command == bus_load) begin
            load_count++;
            last_load_addr = mem_addr;
        end
        if (pending_tag != '0 && mem_tag == pending_tag) begin
            shadow_valid[pending_line % cache_lines] = 1'b1;
            shadow_line[pending_line % cache_lines]  = pending_line;
            pending_tag = '0;
        end
        if (mem_command == bus_load && mem_response != '0) begin
            pending_tag  = mem_response;
            pending_line = mem_addr >> offset_bits;
        end

        if (redirect_valid) begin
            if (inst_valid) report_failure("instruction offered in a redirect cycle");
            model_pc = redirect_pc;
            stalled  = 1'b0;
        end else begin
            if (stalled) begin
                if (!inst_valid) report_failure("inst_valid dropped under back-pressure");
                if (inst_valid && inst !== stall_inst) begin
                    report_mismatch("held inst", stall_inst, inst);
                end
                if (inst_valid && inst_pc !== stall_pc) begin
                    report_mismatch("held inst_pc", stall_pc, inst_pc);
                end
            end else if (inst_valid) begin
                if (inst_pc !== model_pc) report_mismatch("inst_pc", model_pc, inst_pc);
                if (inst !== expected_inst(model_pc)) begin
                    report_mismatch("inst", expected_inst(model_pc), inst);
                end
            end
            stalled    = inst_valid && !inst_ready;
            stall_inst = expected_inst(model_pc);
            stall_pc   = model_pc;
            if (inst_valid && inst_ready) begin
                transfers++;
                model_pc = model_pc + 4;
            end
        end
    endtask

    task automatic step(input logic ready, input logic redirect, input logic [xlen-1:0] target);
        @(posedge clock);
        #1;
        inst_ready     = ready;
        redirect_valid = redirect;
        redirect_pc    = target;
        @(negedge clock);
        observe();
    endtask

    task automatic run_transfers(input int count);
        int goal;
        goal = transfers + count;
        while (transfers < goal) step(random_ready(), 1'b0, '0);
    endtask

    // --------------------
    // Test sequence
    initial begin
        int              goal;
        int              loads_before;
        logic [xlen-1:0] line;
        logic [xlen-1:0] evict_addr;
        logic            saw_refetch;

        void'($urandom(32'h5c0a));
        reset          = 1'b1;
        inst_ready     = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        model_pc       = reset_pc;
        stalled        = 1'b0;
        pending_tag    = '0;
        for (int i = 0; i < cache_lines; i++) shadow_valid[i] = 1'b0;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        start_test("reset");
        @(negedge clock);
        observe();
        if (mem_command !== bus_none) report_mismatch("mem_command", bus_none, mem_command);
        while (mem_tag == '0 && !inst_valid) step(1'b0, 1'b0, '0);
        if (inst_valid) report_failure("inst_valid rose before the first memory response");
        step(1'b0, 1'b0, '0);
        if (!inst_valid) report_failure("first line not offered one cycle after its response");
        finish_test();

        start_test("stream");
        goal = transfers + stream_transfers;
        while (transfers < goal) begin
            if ($urandom % 16 == 0) begin
                step(random_ready(), 1'b1, window_base + ($urandom % 256) * 4);
            end else begin
                step(random_ready(), 1'b0, '0);
            end
        end
        finish_test();

        start_test("hit_loop");
        while (pending_tag != '0) step(1'b0, 1'b0, '0);
        for (int pass = 0; pass < 3; pass++) begin
            if (pass == 1) begin
                for (int i = 0; i < loop_length / 2; i++) begin
                    line = (loop_base >> offset_bits) + i;
                    if (!shadow_valid[line % cache_lines] || shadow_line[line % cache_lines] != line)
                        report_failure("loop line missing from the shadow cache");
                end
                loads_before = load_count;
            end
            step(random_ready(), 1'b1, loop_base);  // Loop back
            run_transfers(loop_length);
        end
        if (load_count != loads_before) begin
            report_mismatch("bus_load cycles", 0, load_count - loads_before);
        end
        finish_test();

        start_test("eviction");
        evict_addr = window_base + 32'h40;
        step(random_ready(), 1'b1, evict_addr);
        run_transfers(1);
        step(random_ready(), 1'b1, evict_addr + cache_lines * line_bytes);  // Same index
        run_transfers(1);
        if (shadow_line[(evict_addr >> offset_bits) % cache_lines] == evict_addr >> offset_bits)
            report_failure("aliasing line did not replace the first line");
        step(random_ready(), 1'b1, evict_addr);
        saw_refetch = 1'b0;
        goal        = transfers + 1;
        while (transfers < goal) begin
            step(random_ready(), 1'b0, '0);
            if (mem_command == bus_load && mem_addr == evict_addr) saw_refetch = 1'b1;
        end
        if (!saw_refetch) report_mismatch("refetch mem_addr", evict_addr, last_load_addr);
        finish_test();

        $display("Tests run: %0d, failed: %0d, errors: %0d, transfers: %0d, cycles: %0d",
                 tests_run, tests_failed, error_count, transfers, cycle_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
hdl/fetch_pkg.sv
hdl/icache.sv
hdl/fetch_stage.sv
hdl/fetch_top.sv
testbench/imem_model.sv
testbench/tb_fetch.sv

//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - hdl/fetch_pkg.sv
  - hdl/icache.sv
  - hdl/fetch_stage.sv
  - hdl/fetch_top.sv
  - target: simulation
    files:
      - testbench/imem_model.sv
      - testbench/tb_fetch.sv
